/* hw/cache_pkg.sv */
// Geometry, field widths and FSM encodings for the four-line cache
// The address layout is fixed at 28-bit tag, 2-bit word and 2-bit byte offsets
// Changing num_lines also needs a wider line index and recency counter
`default_nettype none

package cache_pkg;

  // Geometry
  localparam int addr_width     = 32;
  localparam int word_width     = 32;
  localparam int line_width     = 128;
  localparam int num_lines      = 4;
  localparam int words_per_line = line_width / word_width;

  // Address fields
  localparam int byte_off_width = 2;
  localparam int word_off_width = 2;
  localparam int tag_width      = addr_width - word_off_width - byte_off_width;
  localparam int line_idx_width = 2;

  // Controller states
  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_writeback = 2'd1;
  localparam logic [1:0] st_refill    = 2'd2;
  localparam logic [1:0] st_replay    = 2'd3;

  // Word 0 sits in the low bits
  typedef logic [line_width-1:0] line_t;

  // Raw view goes to memory, field view drives the lookup
  typedef union packed {
    logic [addr_width-1:0] raw;
    struct packed {
      logic [tag_width-1:0]      tag;
      logic [word_off_width-1:0] word_off;
      logic [byte_off_width-1:0] byte_off;
    } fields;
  } cache_addr_t;

endpackage

`default_nettype wire

/* hw/request_register.sv */
// Request capture stage of the cache
// An access is taken only while busy is low; one request is held at a time
// The held fields stay stable until the controller pulses done
`timescale 1ns/1ns
`default_nettype none

module request_register (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              access,
  input  logic                              op,
  input  logic                              byte_op,
  input  logic [cache_pkg::addr_width-1:0]  address,
  input  logic [cache_pkg::word_width-1:0]  data_in,
  input  logic                              done,
  output logic                              busy,
  output logic                              req_op,
  output logic                              req_byte,
  output cache_pkg::cache_addr_t            req_addr,
  output logic [cache_pkg::word_width-1:0]  req_data,
  output logic                              req_start
);

  logic accept;

  // Accepted access, ignored while a request is in flight
  assign accept = access && !busy;

  // Control state
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      req_start <= 1'b0;
    end
    else
    begin
      // One-cycle start for the controller
      req_start <= accept;
      // Busy drops at the edge that samples done
      if (done)
      begin
        busy <= 1'b0;
      end
      else if (accept)
      begin
        busy <= 1'b1;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_op       <= op;
      req_byte     <= byte_op;
      req_addr.raw <= address;
      req_data     <= data_in;
    end
  end

endmodule

`default_nettype wire

/* hw/tag_match.sv */
// Fully associative tag lookup, purely combinational
// A stored tag counts only while its valid bit is set
// Lowest matching line wins, so duplicate tags still give one index
`timescale 1ns/1ns
`default_nettype none

module tag_match (
  input  logic [cache_pkg::tag_width-1:0]                      req_tag,
  input  logic [cache_pkg::num_lines*cache_pkg::tag_width-1:0] tags,
  input  logic [cache_pkg::num_lines-1:0]                      valid,
  output logic                                                 match,
  output logic [cache_pkg::line_idx_width-1:0]                 match_idx
);

  logic [cache_pkg::num_lines-1:0] hit_vec;

  always_comb
  begin
    // One comparator per line
    for (int i = 0; i < cache_pkg::num_lines; i++)
    begin
      hit_vec[i] = valid[i] &&
                   (tags[i*cache_pkg::tag_width +: cache_pkg::tag_width] == req_tag);
    end
    match = |hit_vec;
    // Scan downward so the lowest hit is written last
    match_idx = '0;
    for (int i = cache_pkg::num_lines - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
      begin
        match_idx = cache_pkg::line_idx_width'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/lru_tracker.sv */
// LRU replacement state kept as one recency counter per line
// Counters always form a permutation of 0..num_lines-1, top value is most recent
// Victim is the line whose counter is lowest
`timescale 1ns/1ns
`default_nettype none

module lru_tracker (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 touch,
  input  logic [cache_pkg::line_idx_width-1:0] touch_idx,
  output logic [cache_pkg::line_idx_width-1:0] victim_idx
);

  localparam logic [cache_pkg::line_idx_width-1:0] mru =
    cache_pkg::line_idx_width'(cache_pkg::num_lines - 1);

  logic [cache_pkg::line_idx_width-1:0] cnt_q [cache_pkg::num_lines];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // Line i starts with counter i, so line 0 goes first
      for (int i = 0; i < cache_pkg::num_lines; i++)
      begin
        cnt_q[i] <= cache_pkg::line_idx_width'(i);
      end
    end
    else if (touch)
    begin
      for (int i = 0; i < cache_pkg::num_lines; i++)
      begin
        if (i == touch_idx)
        begin
          cnt_q[i] <= mru;
        end
        // Lines more recent than the touched one move down a step
        else if (cnt_q[i] > cnt_q[touch_idx])
        begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Lowest counter search
  always_comb
  begin
    victim_idx = '0;
    for (int i = 1; i < cache_pkg::num_lines; i++)
    begin
      if (cnt_q[i] < cnt_q[victim_idx])
      begin
        victim_idx = cache_pkg::line_idx_width'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/line_store.sv */
// Tag, valid, dirty and data arrays of the cache
// All writes go to the line picked by idx; the controller never overlaps them
// Refill loads tag and data, sets valid and clears dirty
// Tags and data come up undefined; only valid and dirty are reset
`timescale 1ns/1ns
`default_nettype none

module line_store (
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  logic [cache_pkg::line_idx_width-1:0]                 idx,
  input  logic [cache_pkg::word_off_width-1:0]                 word_off,
  input  logic [cache_pkg::byte_off_width-1:0]                 byte_off,
  input  logic [cache_pkg::word_width-1:0]                     wdata,
  input  logic                                                 word_we,
  input  logic                                                 byte_we,
  input  logic                                                 refill_we,
  input  logic [cache_pkg::tag_width-1:0]                      refill_tag,
  input  cache_pkg::line_t                                     refill_line,
  input  logic                                                 set_dirty,
  output logic [cache_pkg::num_lines*cache_pkg::tag_width-1:0] tags,
  output logic [cache_pkg::num_lines-1:0]                      valid,
  output logic [cache_pkg::num_lines-1:0]                      dirty,
  output logic [cache_pkg::word_width-1:0]                     rword,
  output cache_pkg::line_t                                     rline
);

  logic [cache_pkg::tag_width-1:0] tag_q  [cache_pkg::num_lines];
  cache_pkg::line_t                data_q [cache_pkg::num_lines];

  // Line status bits
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else if (refill_we)
    begin
      valid[idx] <= 1'b1;
      dirty[idx] <= 1'b0;
    end
    else if (set_dirty)
    begin
      dirty[idx] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk)
  begin
    if (refill_we)
    begin
      tag_q[idx]  <= refill_tag;
      data_q[idx] <= refill_line;
    end
    else if (word_we)
    begin
      data_q[idx][word_off*cache_pkg::word_width +: cache_pkg::word_width] <= wdata;
    end
    else if (byte_we)
    begin
      // Only the low byte of wdata lands in the addressed lane
      data_q[idx][word_off*cache_pkg::word_width + byte_off*8 +: 8] <= wdata[7:0];
    end
  end

  // Flattened tags for the parallel lookup
  always_comb
  begin
    for (int i = 0; i < cache_pkg::num_lines; i++)
    begin
      tags[i*cache_pkg::tag_width +: cache_pkg::tag_width] = tag_q[i];
    end
  end

  assign rline = data_q[idx];
  assign rword = rline[word_off*cache_pkg::word_width +: cache_pkg::word_width];

endmodule

`default_nettype wire

/* hw/cache_controller.sv */
// Cache FSM covering lookup, writeback, refill and replay
// Lookup runs in idle on req_start; hit, miss and done are one-cycle pulses
// Memory enables are held until mem_ready; a dirty victim goes out before the refill
// data_out changes only on reads and keeps its value afterwards
`timescale 1ns/1ns
`default_nettype none

module cache_controller (
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  logic                                                 req_start,
  input  logic                                                 req_op,
  input  logic                                                 req_byte,
  input  cache_pkg::cache_addr_t                               req_addr,
  input  logic                                                 match,
  input  logic [cache_pkg::line_idx_width-1:0]                 match_idx,
  input  logic [cache_pkg::line_idx_width-1:0]                 victim_idx,
  input  logic [cache_pkg::num_lines*cache_pkg::tag_width-1:0] tags,
  input  logic [cache_pkg::num_lines-1:0]                      valid,
  input  logic [cache_pkg::num_lines-1:0]                      dirty,
  input  logic [cache_pkg::word_width-1:0]                     rword,
  input  cache_pkg::line_t                                     rline,
  input  logic                                                 mem_ready,
  output logic                                                 hit,
  output logic                                                 miss,
  output logic                                                 done,
  output logic [cache_pkg::word_width-1:0]                     data_out,
  output logic                                                 touch,
  output logic [cache_pkg::line_idx_width-1:0]                 touch_idx,
  output logic [cache_pkg::line_idx_width-1:0]                 idx,
  output logic                                                 word_we,
  output logic                                                 byte_we,
  output logic                                                 refill_we,
  output logic                                                 set_dirty,
  output logic [cache_pkg::addr_width-1:0]                     mem_addr,
  output cache_pkg::line_t                                     mem_data_in,
  output logic                                                 mem_read_enable,
  output logic                                                 mem_write_enable
);

  logic [1:0]                           state_q;
  logic [cache_pkg::line_idx_width-1:0] vict_q;
  logic                                 hit_now;
  logic                                 apply;
  logic                                 vict_dirty;
  logic [cache_pkg::word_width-1:0]     read_word;
  cache_pkg::cache_addr_t               line_addr;

  // Operation is applied on a hit and again on the replay after refill
  assign hit_now    = (state_q == cache_pkg::st_idle) && req_start && match;
  assign apply      = hit_now || (state_q == cache_pkg::st_replay);
  assign vict_dirty = valid[victim_idx] && dirty[victim_idx];

  // Hit works on the matching line, the miss path on the latched victim
  assign idx       = (state_q == cache_pkg::st_idle) ? match_idx : vict_q;
  assign word_we   = apply && !req_op && !req_byte;
  assign byte_we   = apply && !req_op && req_byte;
  assign set_dirty = apply && !req_op;
  assign touch     = apply;
  assign touch_idx = idx;
  assign refill_we = (state_q == cache_pkg::st_refill) && mem_ready;

  // Line-aligned memory address that carries the victim tag during writeback
  always_comb
  begin
    line_addr                 = req_addr;
    line_addr.fields.word_off = '0;
    line_addr.fields.byte_off = '0;
    if (state_q == cache_pkg::st_writeback)
    begin
      line_addr.fields.tag = tags[vict_q*cache_pkg::tag_width +: cache_pkg::tag_width];
    end
  end

  assign mem_addr    = line_addr.raw;
  // Victim line read straight out of the store during writeback
  assign mem_data_in = rline;

  // Byte reads come back zero-extended
  always_comb
  begin
    read_word = rword;
    if (req_byte)
    begin
      read_word      = '0;
      read_word[7:0] = rword[req_addr.fields.byte_off*8 +: 8];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q          <= cache_pkg::st_idle;
      vict_q           <= '0;
      hit              <= 1'b0;
      miss             <= 1'b0;
      done             <= 1'b0;
      mem_read_enable  <= 1'b0;
      mem_write_enable <= 1'b0;
    end
    else
    begin
      hit  <= 1'b0;
      miss <= 1'b0;
      done <= 1'b0;
      case (state_q)
        cache_pkg::st_idle:
        begin
          if (req_start && match)
          begin
            hit  <= 1'b1;
            done <= 1'b1;
          end
          else if (req_start)
          begin
            miss   <= 1'b1;
            vict_q <= victim_idx;
            // Clean or empty victims skip the writeback
            if (vict_dirty)
            begin
              mem_write_enable <= 1'b1;
              state_q          <= cache_pkg::st_writeback;
            end
            else
            begin
              mem_read_enable <= 1'b1;
              state_q         <= cache_pkg::st_refill;
            end
          end
        end
        cache_pkg::st_writeback:
        begin
          if (mem_ready)
          begin
            mem_write_enable <= 1'b0;
            mem_read_enable  <= 1'b1;
            state_q          <= cache_pkg::st_refill;
          end
        end
        cache_pkg::st_refill:
        begin
          if (mem_ready)
          begin
            mem_read_enable <= 1'b0;
            state_q         <= cache_pkg::st_replay;
          end
        end
        default:
        begin
          // Replay of the request on the refilled line
          done    <= 1'b1;
          state_q <= cache_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (apply && req_op)
    begin
      data_out <= read_word;
    end
  end

endmodule

`default_nettype wire

/* hw/cache_top.sv */
// Four-line fully associative write-back cache with write allocate
// access is a one-cycle pulse, legal only while busy is low
// Backing memory answers each held enable with a one-cycle mem_ready
`timescale 1ns/1ns
`default_nettype none

module cache_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             access,
  input  logic                             op,
  input  logic                             byte_op,
  input  logic [cache_pkg::addr_width-1:0] address,
  input  logic [cache_pkg::word_width-1:0] data_in,
  output logic                             busy,
  output logic                             hit,
  output logic                             miss,
  output logic                             done,
  output logic [cache_pkg::word_width-1:0] data_out,
  output logic [cache_pkg::addr_width-1:0] mem_addr,
  output cache_pkg::line_t                 mem_data_in,
  output logic                             mem_read_enable,
  output logic                             mem_write_enable,
  input  cache_pkg::line_t                 mem_data_out,
  input  logic                             mem_ready
);

  // Held request
  logic                                                 req_op;
  logic                                                 req_byte;
  cache_pkg::cache_addr_t                               req_addr;
  logic [cache_pkg::word_width-1:0]                     req_data;
  logic                                                 req_start;

  // Lookup and replacement
  logic                                                 match;
  logic [cache_pkg::line_idx_width-1:0]                 match_idx;
  logic [cache_pkg::line_idx_width-1:0]                 victim_idx;
  logic                                                 touch;
  logic [cache_pkg::line_idx_width-1:0]                 touch_idx;

  // Line store
  logic [cache_pkg::line_idx_width-1:0]                 idx;
  logic                                                 word_we;
  logic                                                 byte_we;
  logic                                                 refill_we;
  logic                                                 set_dirty;
  logic [cache_pkg::num_lines*cache_pkg::tag_width-1:0] tags;
  logic [cache_pkg::num_lines-1:0]                      valid;
  logic [cache_pkg::num_lines-1:0]                      dirty;
  logic [cache_pkg::word_width-1:0]                     rword;
  cache_pkg::line_t                                     rline;

  request_register request_register_i (
    .clk, .reset, .access, .op, .byte_op, .address, .data_in, .done,
    .busy, .req_op, .req_byte, .req_addr, .req_data, .req_start
  );

  tag_match tag_match_i (
    .req_tag   (req_addr.fields.tag),
    .tags, .valid, .match, .match_idx
  );

  lru_tracker lru_tracker_i (
    .clk, .reset, .touch, .touch_idx, .victim_idx
  );

  // Refill takes the memory line and the request tag directly
  line_store line_store_i (
    .clk, .reset, .idx,
    .word_off    (req_addr.fields.word_off),
    .byte_off    (req_addr.fields.byte_off),
    .wdata       (req_data),
    .word_we, .byte_we, .refill_we,
    .refill_tag  (req_addr.fields.tag),
    .refill_line (mem_data_out),
    .set_dirty, .tags, .valid, .dirty, .rword, .rline
  );

  cache_controller cache_controller_i (
    .clk, .reset, .req_start, .req_op, .req_byte, .req_addr,
    .match, .match_idx, .victim_idx, .tags, .valid, .dirty, .rword, .rline,
    .mem_ready, .hit, .miss, .done, .data_out, .touch, .touch_idx,
    .idx, .word_we, .byte_we, .refill_we, .set_dirty,
    .mem_addr, .mem_data_in, .mem_read_enable, .mem_write_enable
  );

endmodule

`default_nettype wire

/* dv/cache_assertions.sv */
// Protocol checks for cache_top, bound in from the testbench
// All properties sample on the rising edge and are idle during reset
// fail_count lets the testbench see that a property fired
`timescale 1ns/1ns
`default_nettype none

module cache_assertions (
  input logic clk,
  input logic reset,
  input logic access,
  input logic busy,
  input logic hit,
  input logic miss,
  input logic done,
  input logic mem_read_enable,
  input logic mem_write_enable,
  input logic mem_ready
);

  int unsigned fail_count = 0;
  logic        accept;

  // Access taken by the request register
  assign accept = access && !busy;

  // Outcomes are exclusive
  hit_miss_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(hit && miss))
  else
  begin
    $error("hit and miss are high in the same cycle");
    fail_count++;
  end

  // Start is registered, so the outcome shows two edges later
  outcome_follows_access: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##2 (hit || miss))
  else
  begin
    $error("accepted access got neither hit nor miss");
    fail_count++;
  end

  // Outcome only once per request
  single_outcome: assert property (@(posedge clk) disable iff (reset)
    (hit || miss) |=> !(hit || miss))
  else
  begin
    $error("hit or miss repeated for one request");
    fail_count++;
  end

  // Hit finishes at once, miss never does
  hit_with_done: assert property (@(posedge clk) disable iff (reset)
    (hit |-> done) and (miss |-> !done))
  else
  begin
    $error("done does not line up with the hit or miss pulse");
    fail_count++;
  end

  // One done pulse, then busy falls
  single_done: assert property (@(posedge clk) disable iff (reset)
    done |-> busy ##1 (!done && !busy))
  else
  begin
    $error("done was not a single pulse ending busy");
    fail_count++;
  end

  // Busy holds from access up to done
  busy_held: assert property (@(posedge clk) disable iff (reset)
    (accept || (busy && !done)) |=> busy)
  else
  begin
    $error("busy dropped before done");
    fail_count++;
  end

  // Memory port
  enables_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mem_read_enable && mem_write_enable))
  else
  begin
    $error("read and write enables are high together");
    fail_count++;
  end

  enables_held: assert property (@(posedge clk) disable iff (reset)
    ((mem_read_enable && !mem_ready) |=> mem_read_enable) and
    ((mem_write_enable && !mem_ready) |=> mem_write_enable))
  else
  begin
    $error("memory enable dropped before mem_ready");
    fail_count++;
  end

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
// Self-checking testbench for the four-line cache
// Memory model answers each enable after 1 to 6 cycles; unwritten lines read as a
// pattern built from the full line address
// Inputs change and outputs are sampled on the falling edge
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

  localparam int          req_timeout  = 64;
  localparam int          idle_timeout = 8;
  localparam int          random_ops   = 160;
  localparam logic [31:0] base         = 32'h0004_2000;

  logic                                   clk = 1'b0;
  logic                                   reset;
  logic                                   access;
  logic                                   op;
  logic                                   byte_op;
  logic [cache_pkg::addr_width-1:0]       address;
  logic [cache_pkg::word_width-1:0]       data_in;
  logic                                   busy;
  logic                                   hit;
  logic                                   miss;
  logic                                   done;
  logic [cache_pkg::word_width-1:0]       data_out;
  logic [cache_pkg::addr_width-1:0]       mem_addr;
  cache_pkg::line_t                       mem_data_in;
  logic                                   mem_read_enable;
  logic                                   mem_write_enable;
  cache_pkg::line_t                       mem_data_out = '0;
  logic                                   mem_ready = 1'b0;

  // Sparse memory model keyed by line address
  cache_pkg::line_t                       mem_lines [logic [31:0]];
  int unsigned                            wr_count = 0;
  int unsigned                            rd_count = 0;
  int unsigned                            latency;
  logic [31:0]                            last_wr_addr;
  cache_pkg::line_t                       last_wr_data;

  // Reference copy of the four lines and their recency counters
  logic [cache_pkg::tag_width-1:0]        ref_tag   [cache_pkg::num_lines];
  logic                                   ref_valid [cache_pkg::num_lines];
  logic                                   ref_dirty [cache_pkg::num_lines];
  cache_pkg::line_t                       ref_data  [cache_pkg::num_lines];
  logic [cache_pkg::line_idx_width-1:0]   ref_cnt   [cache_pkg::num_lines];

  cache_top cache_top_i (
    .clk, .reset, .access, .op, .byte_op, .address, .data_in,
    .busy, .hit, .miss, .done, .data_out,
    .mem_addr, .mem_data_in, .mem_read_enable, .mem_write_enable,
    .mem_data_out, .mem_ready
  );

  bind cache_top cache_assertions cache_assertions_i (
    .clk(clk), .reset(reset), .access(access), .busy(busy), .hit(hit), .miss(miss),
    .done(done), .mem_read_enable(mem_read_enable), .mem_write_enable(mem_write_enable),
    .mem_ready(mem_ready)
  );

  always #2 clk = ~clk;

  // Line content seen by a refill
  function automatic cache_pkg::line_t line_at(input logic [31:0] line_addr);
    cache_pkg::line_t fill;
    if (mem_lines.exists(line_addr))
    begin
      return mem_lines[line_addr];
    end
    for (int w = 0; w < cache_pkg::words_per_line; w++)
    begin
      fill[w*32 +: 32] = {line_addr[15:0], line_addr[31:16]} ^ (32'h1f2e_3d4c * (w + 1));
    end
    return fill;
  endfunction

  // Memory model answers one held enable per loop pass
  always
  begin
    @(negedge clk);
    if (mem_write_enable || mem_read_enable)
    begin
      latency = $urandom_range(6, 1);
      repeat (latency) @(negedge clk);
      if (mem_write_enable)
      begin
        mem_lines[mem_addr] = mem_data_in;
        last_wr_addr        = mem_addr;
        last_wr_data        = mem_data_in;
        wr_count++;
      end
      else
      begin
        mem_data_out = line_at(mem_addr);
        rd_count++;
      end
      mem_ready = 1'b1;
      @(negedge clk);
      mem_ready = 1'b0;
    end
  end

  task automatic abort_run(input string reason);
    $display("%0t: %s", $time, reason);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run("a checked value did not match the reference model");
    end
  endtask

  // Protocol assertion failures end the run at the next falling edge
  always @(negedge clk)
  begin
    if (cache_top_i.cache_assertions_i.fail_count != 0)
    begin
      abort_run("a protocol assertion fired");
    end
  end

  // Touched line becomes most recent and newer lines step down
  function automatic void touch_line(input int slot);
    logic [cache_pkg::line_idx_width-1:0] old;
    old = ref_cnt[slot];
    for (int i = 0; i < cache_pkg::num_lines; i++)
    begin
      if (ref_cnt[i] > old)
      begin
        ref_cnt[i] = ref_cnt[i] - 1'b1;
      end
    end
    ref_cnt[slot] = 2'd3;
  endfunction

  // Predicts, drives and checks one request
  task automatic run_request(input logic rd, input logic bop, input logic [31:0] addr,
                             input logic [31:0] wdata);
    cache_pkg::cache_addr_t a;
    int                     slot;
    int                     vict;
    int                     cycles;
    logic                   exp_hit;
    logic                   exp_wb;
    logic                   saw_hit;
    logic                   saw_miss;
    logic [31:0]            wb_addr;
    logic [31:0]            exp_rd;
    cache_pkg::line_t       wb_data;
    int unsigned            wr_before;
    int unsigned            rd_before;
    a.raw   = addr;
    slot    = -1;
    exp_wb  = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    exp_rd  = '0;
    // Lowest matching line wins
    for (int i = cache_pkg::num_lines - 1; i >= 0; i--)
    begin
      if (ref_valid[i] && ref_tag[i] == a.fields.tag)
      begin
        slot = i;
      end
    end
    exp_hit = (slot >= 0);
    if (!exp_hit)
    begin
      vict = 0;
      for (int i = 1; i < cache_pkg::num_lines; i++)
      begin
        if (ref_cnt[i] < ref_cnt[vict])
        begin
          vict = i;
        end
      end
      // Dirty victim goes back to memory before the refill
      exp_wb          = ref_valid[vict] && ref_dirty[vict];
      wb_addr         = {ref_tag[vict], 4'h0};
      wb_data         = ref_data[vict];
      ref_tag[vict]   = a.fields.tag;
      ref_valid[vict] = 1'b1;
      ref_dirty[vict] = 1'b0;
      ref_data[vict]  = line_at({a.fields.tag, 4'h0});
      slot            = vict;
    end
    if (rd)
    begin
      exp_rd = ref_data[slot][a.fields.word_off*32 +: 32];
      if (bop)
      begin
        exp_rd = {24'h0, exp_rd[a.fields.byte_off*8 +: 8]};
      end
    end
    else
    begin
      if (bop)
      begin
        ref_data[slot][a.fields.word_off*32 + a.fields.byte_off*8 +: 8] = wdata[7:0];
      end
      else
      begin
        ref_data[slot][a.fields.word_off*32 +: 32] = wdata;
      end
      ref_dirty[slot] = 1'b1;
    end
    touch_line(slot);
    // Previous request may still hold busy for one edge
    cycles = 0;
    while (busy && cycles < idle_timeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (busy)
    begin
      abort_run("busy never dropped before a new request");
    end
    wr_before = wr_count;
    rd_before = rd_count;
    access    = 1'b1;
    op        = rd;
    byte_op   = bop;
    address   = addr;
    data_in   = wdata;
    cycles    = 0;
    saw_hit   = 1'b0;
    saw_miss  = 1'b0;
    do
    begin
      @(negedge clk);
      cycles++;
      access   = 1'b0;
      saw_hit  = saw_hit | hit;
      saw_miss = saw_miss | miss;
    end
    while (!done && cycles < req_timeout);
    if (!done)
    begin
      abort_run("request timed out waiting for done");
    end
    check_value("hit", exp_hit, saw_hit);
    check_value("miss", !exp_hit, saw_miss);
    // Hit answers one cycle after the sampling edge
    if (exp_hit)
    begin
      check_value("done latency", 2, cycles);
    end
    if (rd)
    begin
      check_value("data_out", exp_rd, data_out);
    end
    check_value("mem_write_enable count", wr_before + exp_wb, wr_count);
    check_value("mem_read_enable count", rd_before + !exp_hit, rd_count);
    if (exp_wb)
    begin
      check_value("mem_addr", wb_addr, last_wr_addr);
      check_value("mem_data_in", wb_data, last_wr_data);
    end
  endtask

  initial
  begin
    int settle;
    void'($urandom(32'hdcc3b684));
    reset    = 1'b1;
    access   = 1'b0;
    op       = 1'b0;
    byte_op  = 1'b0;
    address  = '0;
    data_in  = '0;
    for (int i = 0; i < cache_pkg::num_lines; i++)
    begin
      ref_tag[i]   = '0;
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_data[i]  = '0;
      ref_cnt[i]   = 2'(i);
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    // Quiet control outputs out of reset
    check_value("busy", 0, busy);
    check_value("hit", 0, hit);
    check_value("miss", 0, miss);
    check_value("done", 0, done);
    check_value("mem_read_enable", 0, mem_read_enable);
    check_value("mem_write_enable", 0, mem_write_enable);
    // Read miss, byte read hit, word read hit
    run_request(1'b1, 1'b0, base + 32'h04, '0);
    run_request(1'b1, 1'b1, base + 32'h06, '0);
    run_request(1'b1, 1'b0, base + 32'h04, '0);
    // Word and byte write hits, then a write miss that allocates
    run_request(1'b0, 1'b0, base + 32'h08, 32'hcafe_f00d);
    run_request(1'b0, 1'b1, base + 32'h09, 32'h0000_005a);
    run_request(1'b1, 1'b0, base + 32'h08, '0);
    run_request(1'b0, 1'b0, base + 32'h40, 32'h1357_9bdf);
    run_request(1'b1, 1'b1, base + 32'h43, '0);
    // Fill four fresh lines
    for (int i = 0; i < 4; i++)
    begin
      run_request(1'b1, 1'b0, base + 32'h100 + 32'(i * 16), '0);
    end
    // Touch order 2 0 3 1 leaves line 0x120 oldest and dirty
    run_request(1'b0, 1'b0, base + 32'h120, 32'h0bad_beef);
    run_request(1'b1, 1'b0, base + 32'h100, '0);
    run_request(1'b0, 1'b1, base + 32'h130, 32'h0000_00c7);
    run_request(1'b1, 1'b0, base + 32'h110, '0);
    // Fifth line evicts 0x120 with a writeback
    run_request(1'b1, 1'b0, base + 32'h140, '0);
    // Only 0x120 misses on revisit, evicting the clean 0x140
    run_request(1'b1, 1'b0, base + 32'h100, '0);
    run_request(1'b1, 1'b0, base + 32'h110, '0);
    run_request(1'b1, 1'b0, base + 32'h130, '0);
    run_request(1'b1, 1'b0, base + 32'h120, '0);
    // Random mix over eight lines
    for (int n = 0; n < random_ops; n++)
    begin
      run_request(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
                  base + 32'h200 + ($urandom_range(7, 0) << 4) + $urandom_range(15, 0),
                  $urandom());
    end
    // Last done retires and its protocol checks settle before the verdict
    settle = 0;
    while (busy && settle < idle_timeout)
    begin
      @(negedge clk);
      settle++;
    end
    if (busy)
    begin
      abort_run("busy never dropped after the last request");
    end
    @(negedge clk);
    if (cache_top_i.cache_assertions_i.fail_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
    begin
      abort_run("a protocol assertion fired during the run");
    end
  end

endmodule

`default_nettype wire

/* flist.f */
hw/cache_pkg.sv
hw/request_register.sv
hw/tag_match.sv
hw/lru_tracker.sv
hw/line_store.sv
hw/cache_controller.sv
hw/cache_top.sv
dv/cache_assertions.sv
dv/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - hw/cache_pkg.sv
  - hw/request_register.sv
  - hw/tag_match.sv
  - hw/lru_tracker.sv
  - hw/line_store.sv
  - hw/cache_controller.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - dv/cache_assertions.sv
      - dv/cache_tb.sv
